//--- common/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int alu_op_w   = 12;

    typedef logic [alu_op_w-1:0] alu_op_t;

    // one-hot alu op bit positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // major opcode in inst[31:26]
    localparam logic [5:0] op_int       = 6'h00;
    localparam logic [5:0] op_lu12i     = 6'h05;
    localparam logic [5:0] op_pcaddu12i = 6'h07;
    localparam logic [5:0] op_mem       = 6'h0a;
    localparam logic [5:0] op_jirl      = 6'h13;
    localparam logic [5:0] op_b         = 6'h14;
    localparam logic [5:0] op_bl        = 6'h15;
    localparam logic [5:0] op_beq       = 6'h16;
    localparam logic [5:0] op_bne       = 6'h17;
    localparam logic [5:0] op_blt       = 6'h18;
    localparam logic [5:0] op_bge       = 6'h19;
    localparam logic [5:0] op_bltu      = 6'h1a;
    localparam logic [5:0] op_bgeu      = 6'h1b;

    // inst[25:22]
    localparam logic [3:0] op4_3r    = 4'h0;
    localparam logic [3:0] op4_shi   = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;
    localparam logic [3:0] op4_st_w  = 4'h6;
    localparam logic [3:0] op4_slti  = 4'h8;
    localparam logic [3:0] op4_sltui = 4'h9;
    localparam logic [3:0] op4_addi  = 4'ha;
    localparam logic [3:0] op4_andi  = 4'hd;
    localparam logic [3:0] op4_ori   = 4'he;
    localparam logic [3:0] op4_xori  = 4'hf;

    // inst[21:20]
    localparam logic [1:0] op2_shi = 2'h0;
    localparam logic [1:0] op2_3r  = 2'h1;

    // inst[19:15]
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_sll  = 5'h0e;
    localparam logic [4:0] op5_srl  = 5'h0f;
    localparam logic [4:0] op5_sra  = 5'h10;
    localparam logic [4:0] op5_srai = 5'h11;

    typedef enum logic [3:0] {
        br_none, br_b, br_bl, br_jirl, br_beq,
        br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } br_kind_t;

    typedef enum logic [2:0] {
        imm_none, imm_four, imm_ui5, imm_si12, imm_ui12, imm_si20
    } imm_kind_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   need_r1;
        logic                   need_r2;
        logic                   src_reg_is_rd;
        logic                   res_from_mem;
        logic                   mem_we;
        logic                   rf_we;
        logic [reg_addr_w-1:0]  dest;
        br_kind_t               br;
    } ds_ctrl_t;

endpackage

`default_nettype wire

//--- common/fwd_if.sv
`timescale 1ns/100ps
`default_nettype none

// register-write reports from execute, memory and writeback
interface fwd_if import id_pkg::*; ();

    logic                   es_we;
    logic [reg_addr_w-1:0]  es_waddr;
    logic [xlen-1:0]        es_wdata;
    logic                   es_res_from_mem;
    logic                   ms_we;
    logic [reg_addr_w-1:0]  ms_waddr;
    logic [xlen-1:0]        ms_wdata;
    logic                   ws_we;
    logic [reg_addr_w-1:0]  ws_waddr;
    logic [xlen-1:0]        ws_wdata;

    modport src (
        output es_we, es_waddr, es_wdata, es_res_from_mem,
        output ms_we, ms_waddr, ms_wdata,
        output ws_we, ws_waddr, ws_wdata
    );

    modport dst (
        input es_we, es_waddr, es_wdata, es_res_from_mem,
        input ms_we, ms_waddr, ms_wdata,
        input ws_we, ws_waddr, ws_wdata
    );

endinterface

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile import id_pkg::*; (
    input  logic                    clk,
    input  logic [reg_addr_w-1:0]   raddr1,
    input  logic [reg_addr_w-1:0]   raddr2,
    input  logic                    we,
    input  logic [reg_addr_w-1:0]   waddr,
    input  logic [xlen-1:0]         wdata,
    output logic [xlen-1:0]         rdata1,
    output logic [xlen-1:0]         rdata2
);

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit import id_pkg::*; (
    input  logic            valid,
    input  logic [xlen-1:0] inst,
    input  logic [xlen-1:0] pc,
    input  ds_ctrl_t        ctrl,
    input  logic [xlen-1:0] rj_value,
    input  logic [xlen-1:0] rkd_value,
    output logic            br_taken,
    output logic [xlen-1:0] br_target
);

    logic               eq;
    logic               ge_s;
    logic               ge_u;
    logic               cond;
    logic [xlen-1:0]    offs16;
    logic [xlen-1:0]    offs26;

    assign eq   = (rj_value == rkd_value);
    assign ge_s = ($signed(rj_value) >= $signed(rkd_value));
    assign ge_u = (rj_value >= rkd_value);

    always_comb begin
        case (ctrl.br)
            br_b, br_bl, br_jirl: cond = 1'b1;
            br_beq:  cond = eq;
            br_bne:  cond = !eq;
            br_blt:  cond = !ge_s;
            br_bge:  cond = ge_s;
            br_bltu: cond = !ge_u;
            br_bgeu: cond = ge_u;
            default: cond = 1'b0;
        endcase
    end

    assign br_taken = valid & cond;

    // offs26 high part sits in inst[9:0]
    assign offs16 = {{(xlen-18){inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{(xlen-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        case (ctrl.br)
            br_jirl:     br_target = rj_value + offs16;
            br_b, br_bl: br_target = pc + offs26;
            default:     br_target = pc + offs16;
        endcase
    end

endmodule

`default_nettype wire

//--- decode/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  logic [xlen-1:0] inst,
    output ds_ctrl_t        ctrl,
    output logic [xlen-1:0] imm
);

    wire [5:0]            op_31_26 = inst[31:26];
    wire [3:0]            op_25_22 = inst[25:22];
    wire [1:0]            op_21_20 = inst[21:20];
    wire [4:0]            op_19_15 = inst[19:15];
    wire [reg_addr_w-1:0] rd       = inst[4:0];
    wire [reg_addr_w-1:0] rk       = inst[14:10];
    wire [11:0]           i12      = inst[21:10];
    wire [19:0]           i20      = inst[24:5];

    // predecoded groups
    wire is_int = (op_31_26 == op_int);
    wire is_3r  = is_int && (op_25_22 == op4_3r) && (op_21_20 == op2_3r);
    wire is_shi = is_int && (op_25_22 == op4_shi) && (op_21_20 == op2_shi);
    wire is_mem = (op_31_26 == op_mem);

    wire inst_add_w  = is_3r && (op_19_15 == op5_add);
    wire inst_sub_w  = is_3r && (op_19_15 == op5_sub);
    wire inst_slt    = is_3r && (op_19_15 == op5_slt);
    wire inst_sltu   = is_3r && (op_19_15 == op5_sltu);
    wire inst_nor    = is_3r && (op_19_15 == op5_nor);
    wire inst_and    = is_3r && (op_19_15 == op5_and);
    wire inst_or     = is_3r && (op_19_15 == op5_or);
    wire inst_xor    = is_3r && (op_19_15 == op5_xor);
    wire inst_sll_w  = is_3r && (op_19_15 == op5_sll);
    wire inst_srl_w  = is_3r && (op_19_15 == op5_srl);
    wire inst_sra_w  = is_3r && (op_19_15 == op5_sra);
    wire inst_slli_w = is_shi && (op_19_15 == op5_slli);
    wire inst_srli_w = is_shi && (op_19_15 == op5_srli);
    wire inst_srai_w = is_shi && (op_19_15 == op5_srai);

    wire inst_slti   = is_int && (op_25_22 == op4_slti);
    wire inst_sltui  = is_int && (op_25_22 == op4_sltui);
    wire inst_addi_w = is_int && (op_25_22 == op4_addi);
    wire inst_andi   = is_int && (op_25_22 == op4_andi);
    wire inst_ori    = is_int && (op_25_22 == op4_ori);
    wire inst_xori   = is_int && (op_25_22 == op4_xori);

    wire inst_lu12i  = (op_31_26 == op_lu12i) && !inst[25];
    wire inst_pcaddu = (op_31_26 == op_pcaddu12i) && !inst[25];
    wire inst_ld_w   = is_mem && (op_25_22 == op4_ld_w);
    wire inst_st_w   = is_mem && (op_25_22 == op4_st_w);

    wire inst_jirl   = (op_31_26 == op_jirl);
    wire inst_b      = (op_31_26 == op_b);
    wire inst_bl     = (op_31_26 == op_bl);
    wire is_cond_br  = (op_31_26 >= op_beq) && (op_31_26 <= op_bgeu);

    imm_kind_t imm_kind;

    always_comb begin
        if (inst_jirl || inst_bl) begin
            imm_kind = imm_four;
        end else if (inst_lu12i || inst_pcaddu) begin
            imm_kind = imm_si20;
        end else if (inst_addi_w || inst_slti || inst_sltui || inst_ld_w || inst_st_w) begin
            imm_kind = imm_si12;
        end else if (inst_andi || inst_ori || inst_xori) begin
            imm_kind = imm_ui12;
        end else if (inst_slli_w || inst_srli_w || inst_srai_w) begin
            imm_kind = imm_ui5;
        end else begin
            imm_kind = imm_none;
        end
    end

    always_comb begin
        case (imm_kind)
            imm_four: imm = xlen'(4);
            imm_ui5:  imm = {{(xlen-reg_addr_w){1'b0}}, rk};
            imm_si12: imm = {{(xlen-12){i12[11]}}, i12};
            imm_ui12: imm = {{(xlen-12){1'b0}}, i12};
            imm_si20: imm = {i20, 12'b0};
            default:  imm = '0;
        endcase
    end

    always_comb begin
        ctrl.alu_op = '0;
        ctrl.alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                              | inst_jirl | inst_bl | inst_pcaddu;
        ctrl.alu_op[alu_sub]  = inst_sub_w;
        ctrl.alu_op[alu_slt]  = inst_slt | inst_slti;
        ctrl.alu_op[alu_sltu] = inst_sltu | inst_sltui;
        ctrl.alu_op[alu_and]  = inst_and | inst_andi;
        ctrl.alu_op[alu_nor]  = inst_nor;
        ctrl.alu_op[alu_or]   = inst_or | inst_ori;
        ctrl.alu_op[alu_xor]  = inst_xor | inst_xori;
        ctrl.alu_op[alu_sll]  = inst_sll_w | inst_slli_w;
        ctrl.alu_op[alu_srl]  = inst_srl_w | inst_srli_w;
        ctrl.alu_op[alu_sra]  = inst_sra_w | inst_srai_w;
        ctrl.alu_op[alu_lui]  = inst_lu12i;

        ctrl.src1_is_pc    = inst_jirl | inst_bl | inst_pcaddu;
        ctrl.src2_is_imm   = (imm_kind != imm_none);
        // jirl needs rj for its target even though its alu source is pc
        ctrl.need_r1       = !(inst_lu12i | inst_pcaddu | inst_b | inst_bl);
        ctrl.need_r2       = is_3r | inst_st_w | is_cond_br;
        ctrl.src_reg_is_rd = inst_st_w | is_cond_br;
        ctrl.res_from_mem  = inst_ld_w;
        ctrl.mem_we        = inst_st_w;
        ctrl.rf_we         = !(inst_st_w | inst_b | is_cond_br);
        ctrl.dest          = inst_bl ? reg_addr_w'(1) : rd;

        case (op_31_26)
            op_jirl: ctrl.br = br_jirl;
            op_b:    ctrl.br = br_b;
            op_bl:   ctrl.br = br_bl;
            op_beq:  ctrl.br = br_beq;
            op_bne:  ctrl.br = br_bne;
            op_blt:  ctrl.br = br_blt;
            op_bge:  ctrl.br = br_bge;
            op_bltu: ctrl.br = br_bltu;
            op_bgeu: ctrl.br = br_bgeu;
            default: ctrl.br = br_none;
        endcase
    end

endmodule

`default_nettype wire

//--- decode/operand_bypass.sv
`timescale 1ns/100ps
`default_nettype none

module operand_bypass import id_pkg::*; (
    input  logic            clk,
    input  logic [xlen-1:0] inst,
    input  ds_ctrl_t        ctrl,
    fwd_if.dst              fwd,
    output logic [xlen-1:0] rj_value,
    output logic [xlen-1:0] rkd_value,
    output logic            load_use_stall
);

    logic [reg_addr_w-1:0]  raddr1;
    logic [reg_addr_w-1:0]  raddr2;
    logic [xlen-1:0]        rdata1;
    logic [xlen-1:0]        rdata2;
    logic                   es_hit1;
    logic                   es_hit2;

    // youngest producer wins, r0 never forwarded
    function automatic logic [xlen-1:0] bypass(input logic [reg_addr_w-1:0] addr,
                                               input logic [xlen-1:0] rf_data);
        if (addr == '0) begin
            return rf_data;
        end
        if (fwd.es_we && fwd.es_waddr == addr) begin
            return fwd.es_wdata;
        end
        if (fwd.ms_we && fwd.ms_waddr == addr) begin
            return fwd.ms_wdata;
        end
        if (fwd.ws_we && fwd.ws_waddr == addr) begin
            return fwd.ws_wdata;
        end
        return rf_data;
    endfunction

    assign raddr1 = inst[9:5];
    assign raddr2 = ctrl.src_reg_is_rd ? inst[4:0] : inst[14:10];

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (fwd.ws_we),
        .waddr  (fwd.ws_waddr),
        .wdata  (fwd.ws_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    always_comb begin
        rj_value  = bypass(raddr1, rdata1);
        rkd_value = bypass(raddr2, rdata2);
    end

    // load data is not ready until memory stage
    assign es_hit1 = ctrl.need_r1 && (raddr1 != '0) && (raddr1 == fwd.es_waddr);
    assign es_hit2 = ctrl.need_r2 && (raddr2 != '0) && (raddr2 == fwd.es_waddr);
    assign load_use_stall = fwd.es_res_from_mem && fwd.es_we && (es_hit1 || es_hit2);

endmodule

`default_nettype wire

//--- decode/id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    fs_to_ds_valid,
    input  logic [xlen-1:0]         fs_inst,
    input  logic [xlen-1:0]         fs_pc,
    input  logic                    es_allowin,

    input  logic                    es_rf_we,
    input  logic [reg_addr_w-1:0]   es_rf_waddr,
    input  logic [xlen-1:0]         es_rf_wdata,
    input  logic                    es_res_from_mem,
    input  logic                    ms_rf_we,
    input  logic [reg_addr_w-1:0]   ms_rf_waddr,
    input  logic [xlen-1:0]         ms_rf_wdata,
    input  logic                    ws_rf_we,
    input  logic [reg_addr_w-1:0]   ws_rf_waddr,
    input  logic [xlen-1:0]         ws_rf_wdata,

    output logic                    ds_allowin,
    output logic                    ds_to_es_valid,
    output alu_op_t                 alu_op,
    output logic [xlen-1:0]         alu_src1,
    output logic [xlen-1:0]         alu_src2,
    output logic [xlen-1:0]         rkd_value,
    output logic [xlen-1:0]         ds_pc,
    output logic                    res_from_mem,
    output logic                    mem_we,
    output logic                    rf_we,
    output logic [reg_addr_w-1:0]   rf_waddr,
    output logic                    br_taken,
    output logic [xlen-1:0]         br_target
);

    logic               ds_valid;
    logic [xlen-1:0]    ds_inst;
    logic               ds_ready_go;
    ds_ctrl_t           ctrl;
    logic [xlen-1:0]    imm;
    logic [xlen-1:0]    rj_value;
    logic               load_use_stall;

    fwd_if fwd ();

    assign fwd.es_we           = es_rf_we;
    assign fwd.es_waddr        = es_rf_waddr;
    assign fwd.es_wdata        = es_rf_wdata;
    assign fwd.es_res_from_mem = es_res_from_mem;
    assign fwd.ms_we           = ms_rf_we;
    assign fwd.ms_waddr        = ms_rf_waddr;
    assign fwd.ms_wdata        = ms_rf_wdata;
    assign fwd.ws_we           = ws_rf_we;
    assign fwd.ws_waddr        = ws_rf_waddr;
    assign fwd.ws_wdata        = ws_rf_wdata;

    assign ds_ready_go    = ~load_use_stall;
    assign ds_allowin     = ~ds_valid | (ds_ready_go & es_allowin);
    assign ds_to_es_valid = ds_valid & ds_ready_go;

    // a taken branch squashes whatever fetch offers alongside it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid & ~br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder u_decoder (
        .inst   (ds_inst),
        .ctrl   (ctrl),
        .imm    (imm)
    );

    operand_bypass u_bypass (
        .clk            (clk),
        .inst           (ds_inst),
        .ctrl           (ctrl),
        .fwd            (fwd.dst),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_branch (
        .valid      (ds_valid),
        .inst       (ds_inst),
        .pc         (ds_pc),
        .ctrl       (ctrl),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .br_taken   (br_taken),
        .br_target  (br_target)
    );

    assign alu_op       = ctrl.alu_op;
    assign alu_src1     = ctrl.src1_is_pc  ? ds_pc : rj_value;
    assign alu_src2     = ctrl.src2_is_imm ? imm   : rkd_value;
    assign res_from_mem = ctrl.res_from_mem;
    assign mem_we       = ctrl.mem_we & ds_valid;
    assign rf_we        = ctrl.rf_we;
    assign rf_waddr     = ctrl.dest;

endmodule

`default_nettype wire

//--- dv/tb_id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    logic               clk;
    logic               resetn;
    logic               fs_to_ds_valid;
    logic [xlen-1:0]    fs_inst;
    logic [xlen-1:0]    fs_pc;
    logic               es_allowin;
    logic               es_rf_we;
    logic [4:0]         es_rf_waddr;
    logic [xlen-1:0]    es_rf_wdata;
    logic               es_res_from_mem;
    logic               ms_rf_we;
    logic [4:0]         ms_rf_waddr;
    logic [xlen-1:0]    ms_rf_wdata;
    logic               ws_rf_we;
    logic [4:0]         ws_rf_waddr;
    logic [xlen-1:0]    ws_rf_wdata;
    logic               ds_allowin;
    logic               ds_to_es_valid;
    alu_op_t            alu_op;
    logic [xlen-1:0]    alu_src1;
    logic [xlen-1:0]    alu_src2;
    logic [xlen-1:0]    rkd_value;
    logic [xlen-1:0]    ds_pc;
    logic               res_from_mem;
    logic               mem_we;
    logic               rf_we;
    logic [4:0]         rf_waddr;
    logic               br_taken;
    logic [xlen-1:0]    br_target;

    int                 errors;
    int                 other_errors;
    int                 fd;
    logic               aborted;
    // one vector: inst, pc, offer, es_allowin, es/ms/ws fields, then expected outputs
    logic [31:0]        f [26];

    id_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic clear_fwd();
        es_rf_we        = 1'b0;
        es_rf_waddr     = '0;
        es_rf_wdata     = '0;
        es_res_from_mem = 1'b0;
        ms_rf_we        = 1'b0;
        ms_rf_waddr     = '0;
        ms_rf_wdata     = '0;
        ws_rf_we        = 1'b0;
        ws_rf_waddr     = '0;
        ws_rf_wdata     = '0;
    endtask

    task automatic apply_stage_inputs();
        es_allowin      = f[3][0];
        es_rf_we        = f[4][0];
        es_rf_waddr     = f[5][4:0];
        es_rf_wdata     = f[6];
        es_res_from_mem = f[7][0];
        ms_rf_we        = f[8][0];
        ms_rf_waddr     = f[9][4:0];
        ms_rf_wdata     = f[10];
        ws_rf_we        = f[11][0];
        ws_rf_waddr     = f[12][4:0];
        ws_rf_wdata     = f[13];
    endtask

    task automatic compare_outputs();
        check_value("ds_allowin", ds_allowin, f[14]);
        check_value("ds_to_es_valid", ds_to_es_valid, f[15]);
        check_value("alu_op", alu_op, f[16]);
        check_value("alu_src1", alu_src1, f[17]);
        check_value("alu_src2", alu_src2, f[18]);
        check_value("rkd_value", rkd_value, f[19]);
        check_value("ds_pc", ds_pc, f[1]);
        check_value("res_from_mem", res_from_mem, f[20]);
        check_value("mem_we", mem_we, f[21]);
        check_value("rf_we", rf_we, f[22]);
        check_value("rf_waddr", rf_waddr, f[23]);
        check_value("br_taken", br_taken, f[24]);
        // target only matters when the branch is taken
        if (f[24][0]) begin
            check_value("br_target", br_target, f[25]);
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        ws_rf_we    = 1'b1;
        ws_rf_waddr = addr;
        ws_rf_wdata = data;
        @(negedge clk);
        ws_rf_we    = 1'b0;
    endtask

    // returns on a falling edge with the stage free
    task automatic wait_allowin();
        int cycles;
        cycles = 0;
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        es_allowin     = 1'b1;
        clear_fwd();
        #2;
        while (!ds_allowin) begin
            if (cycles >= 100) begin
                other_errors++;
                aborted = 1'b1;
                $display("timeout: decode stage never raised ds_allowin");
                return;
            end
            @(negedge clk);
            #2;
            cycles++;
        end
        @(negedge clk);
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        #2;
        while (!ds_to_es_valid) begin
            if (cycles >= 100) begin
                other_errors++;
                aborted = 1'b1;
                $display("timeout: stalled instruction never left the decode stage");
                return;
            end
            @(negedge clk);
            #2;
            cycles++;
        end
    endtask

    task automatic issue_vector();
        wait_allowin();
        if (aborted) begin
            return;
        end
        fs_to_ds_valid = 1'b1;
        fs_inst        = f[0];
        fs_pc          = f[1];
        @(negedge clk);
        // optional second offer, squashed by a taken branch
        fs_to_ds_valid = f[2][0];
        fs_inst        = 32'h00101488;
        fs_pc          = f[1] + 32'd4;
        apply_stage_inputs();
        #2;
        compare_outputs();
        if (f[2][0]) begin
            @(negedge clk);
            fs_to_ds_valid = 1'b0;
            #2;
            check_value("ds_to_es_valid", ds_to_es_valid, 32'd0);
            check_value("br_taken", br_taken, 32'd0);
        end
    endtask

    task automatic hold_vector();
        @(negedge clk);
        apply_stage_inputs();
        if (f[15][0]) begin
            wait_valid();
        end else begin
            #2;
        end
        compare_outputs();
    endtask

    task automatic read_fields(input int first, input int last);
        int r;
        for (int i = first; i <= last; i++) begin
            r = $fscanf(fd, "%h", f[i]);
            if (r != 1) begin
                other_errors++;
                aborted = 1'b1;
                $display("test data line is missing fields");
                return;
            end
        end
    endtask

    task automatic run_vectors();
        logic [63:0]        tok;
        logic [8*256-1:0]   rest;
        int                 r;
        while (!aborted) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) begin
                break;
            end
            if (tok == "#") begin
                r = $fgets(rest, fd);
            end else if (tok == "W") begin
                read_fields(0, 1);
                if (!aborted) begin
                    write_reg(f[0][4:0], f[1]);
                end
            end else if (tok == "I") begin
                read_fields(0, 25);
                if (!aborted) begin
                    issue_vector();
                end
            end else if (tok == "S") begin
                read_fields(3, 25);
                if (!aborted) begin
                    hold_vector();
                end
            end else begin
                other_errors++;
                $display("unknown command in test data");
                break;
            end
        end
    endtask

    initial begin
        errors         = 0;
        other_errors   = 0;
        aborted        = 1'b0;
        resetn         = 1'b0;
        // a store offered under reset must not reach the outputs
        fs_to_ds_valid = 1'b1;
        fs_inst        = 32'h29802086;
        fs_pc          = 32'h1c000000;
        es_allowin     = 1'b1;
        clear_fwd();
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn         = 1'b1;
        fs_to_ds_valid = 1'b0;
        #2;
        check_value("ds_to_es_valid", ds_to_es_valid, 32'd0);
        check_value("br_taken", br_taken, 32'd0);
        check_value("mem_we", mem_we, 32'd0);
        // register file has no reset
        for (int i = 1; i < num_regs; i++) begin
            write_reg(i[4:0], 32'd0);
        end
        fd = $fopen("dv/id_testdata.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the test data file");
        end else begin
            run_vectors();
            $fclose(fd);
        end
        $display("errors: %0d value mismatches, %0d other failures", errors, other_errors);
        if (errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/id_testdata.txt
# W addr data | I inst pc offer es_allowin es_we es_addr es_data es_mem ms_we ms_addr ms_data ws_we ws_addr ws_data
# then: ds_allowin valid alu_op src1 src2 rkd res_mem mem_we rf_we waddr br_taken br_target (S drops inst pc offer)
W 4 00000010
W 5 fffffff0
W 6 00000010
I 00101488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 001 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00111488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 002 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00121488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 004 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00129488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 008 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00141488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 020 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00149488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 010 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00151488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 040 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00171488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 100 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00179488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 200 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00181488 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 400 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00408c88 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 100 00000010 00000003 00000000 0 0 1 8 0 0
I 00448c88 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 200 00000010 00000003 00000000 0 0 1 8 0 0
I 00488c88 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 400 00000010 00000003 00000000 0 0 1 8 0 0
I 02bff088 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 001 00000010 fffffffc 00000000 0 0 1 8 0 0
I 023ff088 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 004 00000010 fffffffc 00000000 0 0 1 8 0 0
I 027ff088 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 008 00000010 fffffffc 00000000 0 0 1 8 0 0
I 037ff088 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 010 00000010 00000ffc 00000000 0 0 1 8 0 0
I 03bff088 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 040 00000010 00000ffc 00000000 0 0 1 8 0 0
I 03fff088 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 080 00000010 00000ffc 00000000 0 0 1 8 0 0
I 142468a8 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 800 fffffff0 12345000 00000000 0 0 1 8 0 0
I 1c2468a8 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 001 1c000100 12345000 00000000 0 0 1 8 0 0
I 28bff088 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 001 00000010 fffffffc 00000000 1 0 1 8 0 0
I 29802086 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 001 00000010 00000008 00000010 0 1 0 6 0 0
I 58001086 1c000100 1 1 0 0 0 0 0 0 0 0 0 0 1 1 000 00000010 00000010 00000010 0 0 0 6 1 1c000110
I 5c001086 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 000 00000010 00000010 00000010 0 0 0 6 0 0
I 63fff0a4 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 000 fffffff0 00000010 00000010 0 0 0 4 1 1c0000f0
I 67fff0a4 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 000 fffffff0 00000010 00000010 0 0 0 4 0 0
I 6bfff0a4 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 000 fffffff0 00000010 00000010 0 0 0 4 0 0
I 6ffff0a4 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 000 fffffff0 00000010 00000010 0 0 0 4 1 1c0000f0
I 50010000 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 000 00000000 00000000 00000000 0 0 0 0 1 1c000200
I 54010000 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 001 1c000100 00000004 00000000 0 0 1 1 1 1c000200
I 4c000881 1c000100 0 1 0 0 0 0 0 0 0 0 0 0 1 1 001 1c000100 00000004 00000000 0 0 1 1 1 00000018
I 00101488 1c000100 0 1 1 4 00005555 1 0 0 0 0 0 0 0 0 001 00005555 fffffff0 fffffff0 0 0 1 8 0 0
S 1 0 0 0 0 1 4 00005555 0 0 0 1 1 001 00005555 fffffff0 fffffff0 0 0 1 8 0 0
I 00159488 1c000100 0 0 0 0 0 0 0 0 0 0 0 0 0 1 080 00000010 fffffff0 fffffff0 0 0 1 8 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 1 080 00000010 fffffff0 fffffff0 0 0 1 8 0 0
I 00102928 1c000100 0 1 1 9 aaaa0001 0 1 9 bbbb0002 1 9 cccc0003 1 1 001 aaaa0001 00000000 00000000 0 0 1 8 0 0
I 00102928 1c000100 0 1 0 0 0 0 0 0 0 1 a dddd0004 1 1 001 cccc0003 dddd0004 dddd0004 0 0 1 8 0 0
I 00100008 1c000100 0 1 1 0 12345678 0 1 0 12345678 1 0 12345678 1 1 001 00000000 00000000 00000000 0 0 1 8 0 0

//--- all.f
common/id_pkg.sv
common/fwd_if.sv
logic/regfile.sv
logic/branch_unit.sv
decode/inst_decoder.sv
decode/operand_bypass.sv
decode/id_stage.sv
dv/tb_id_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_id_stage -f all.f
./obj_dir/Vtb_id_stage | tee sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0
